// File: hw/ddr4_ca_macros.svh
`ifndef DDR4_CA_MACROS_SVH
`define DDR4_CA_MACROS_SVH

// ==============================
// Bus geometry
// ==============================

// A16..A14 double as RAS_n/CAS_n/WE_n
`define DDR4_ADDR_W 17

// Four x16 parts in clamshell, two per rank
`define DDR4_NUM_DEV 4

// One chip select per rank
`define DDR4_NUM_RANK 2

// ==============================
// Command tally
// ==============================

`define DDR4_CNT_W 16

// Clears A13..A11 on column commands
`define DDR4_WRRD_MASK 17'h1C7FF

`endif

// File: hw/ddr4_ca_pkg.sv
`include "ddr4_ca_macros.svh"

package ddr4_ca_pkg;

  // Opcodes on A16..A14 when act_n is high
  localparam logic [2:0] OP_MRS = 3'b000;
  localparam logic [2:0] OP_REF = 3'b001;
  localparam logic [2:0] OP_PRE = 3'b010;
  localparam logic [2:0] OP_ACT = 3'b011;
  localparam logic [2:0] OP_WR  = 3'b100;
  localparam logic [2:0] OP_RD  = 3'b101;
  localparam logic [2:0] OP_ZQC = 3'b110;
  localparam logic [2:0] OP_NOP = 3'b111;

  typedef enum logic [3:0] {
    DSEL = 4'd0,
    MRS  = 4'd1,
    REF  = 4'd2,
    PRE  = 4'd3,
    ACT  = 4'd4,
    WR   = 4'd5,
    RD   = 4'd6,
    ZQC  = 4'd7,
    NOP  = 4'd8
  } ddr4_cmd_e;

  // One rank's view of the bus after the input register
  typedef struct packed {
    logic                    act_n;
    logic [`DDR4_ADDR_W-1:0] adr;
    logic [1:0]              ba;
    logic [0:0]              bg;
    logic                    cs_n;
    logic                    reset_n;
  } ca_sample_t;

endpackage

// File: hw/ddr4_ca_if.sv
`timescale 1ns/1ps

`include "ddr4_ca_macros.svh"

// Command/address bus as seen by the parts of one rank
interface ddr4_ca_if;

  logic                    act_n;
  logic [`DDR4_ADDR_W-1:0] adr;
  logic [1:0]              ba;
  logic [0:0]              bg;
  logic                    cs_n;
  logic                    reset_n;

  // Mirror side
  modport src (
    output act_n,
    output adr,
    output ba,
    output bg,
    output cs_n,
    output reset_n
  );

  // Device side
  modport dst (
    input act_n,
    input adr,
    input ba,
    input bg,
    input cs_n,
    input reset_n
  );

endinterface

// File: hw/ddr4_dev_if.sv
`timescale 1ns/1ps

`include "ddr4_ca_macros.svh"

// Decoded view of one x16 part
interface ddr4_dev_if;

  ddr4_ca_pkg::ddr4_cmd_e  cmd;
  logic [`DDR4_ADDR_W-1:0] adr_mod;
  logic [1:0]              ba;
  logic [0:0]              bg;
  logic                    wr_mode;

  modport src (
    output cmd,
    output adr_mod,
    output ba,
    output bg,
    output wr_mode
  );

  modport dst (
    input cmd,
    input adr_mod,
    input ba,
    input bg,
    input wr_mode
  );

endinterface

// File: hw/ddr4_ca_mirror.sv
`timescale 1ns/1ps

`include "ddr4_ca_macros.svh"

module ddr4_ca_mirror (
  input  logic                      c0_ddr4_ck_t,
  input  logic                      i_arst_n,
  input  logic                      i_act_n,
  input  logic [`DDR4_ADDR_W-1:0]   i_adr,
  input  logic [1:0]                i_ba,
  input  logic [0:0]                i_bg,
  input  logic [`DDR4_NUM_RANK-1:0] i_cs_n,
  input  logic                      i_reset_n,
  ddr4_ca_if.src                    o_rank0,
  ddr4_ca_if.src                    o_rank1
);

  localparam ddr4_ca_pkg::ca_sample_t RST_VIEW = '{
    act_n: 1'b1, adr: '0, ba: '0, bg: '0, cs_n: 1'b1, reset_n: 1'b0
  };

  logic [`DDR4_ADDR_W-1:0] w_adr_mir;
  ddr4_ca_pkg::ca_sample_t w_view [`DDR4_NUM_RANK];
  ddr4_ca_pkg::ca_sample_t r_view [`DDR4_NUM_RANK];

  // A12 and the upper opcode bits stay in place under clamshell mirroring
  assign w_adr_mir = {i_adr[`DDR4_ADDR_W-1:14], i_adr[11], i_adr[12], i_adr[13],
                      i_adr[10:9], i_adr[7], i_adr[8], i_adr[5], i_adr[6],
                      i_adr[3], i_adr[4], i_adr[2:0]};

  always_comb begin
    w_view[0] = '{act_n: i_act_n, adr: i_adr, ba: i_ba, bg: i_bg,
                  cs_n: i_cs_n[0], reset_n: i_reset_n};
    // Back side parts also see BA0/BA1 swapped
    w_view[1] = '{act_n: i_act_n, adr: w_adr_mir, ba: {i_ba[0], i_ba[1]}, bg: i_bg,
                  cs_n: i_cs_n[1], reset_n: i_reset_n};
  end

  always_ff @(posedge c0_ddr4_ck_t or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int r = 0; r < `DDR4_NUM_RANK; r++) begin
        r_view[r] <= RST_VIEW;
      end
    end else begin
      r_view <= w_view;
    end
  end

  // ==============================
  // Rank views
  // ==============================
  assign o_rank0.act_n   = r_view[0].act_n;
  assign o_rank0.adr     = r_view[0].adr;
  assign o_rank0.ba      = r_view[0].ba;
  assign o_rank0.bg      = r_view[0].bg;
  assign o_rank0.cs_n    = r_view[0].cs_n;
  assign o_rank0.reset_n = r_view[0].reset_n;

  assign o_rank1.act_n   = r_view[1].act_n;
  assign o_rank1.adr     = r_view[1].adr;
  assign o_rank1.ba      = r_view[1].ba;
  assign o_rank1.bg      = r_view[1].bg;
  assign o_rank1.cs_n    = r_view[1].cs_n;
  assign o_rank1.reset_n = r_view[1].reset_n;

endmodule

// File: hw/ddr4_dev_decode.sv
`timescale 1ns/1ps

`include "ddr4_ca_macros.svh"

module ddr4_dev_decode (
  input  logic    c0_ddr4_ck_t,
  input  logic    i_arst_n,
  ddr4_ca_if.dst  i_ca,
  ddr4_dev_if.src o_dev
);

  ddr4_ca_pkg::ddr4_cmd_e  w_cmd;
  logic                    w_wrrd;
  logic [`DDR4_ADDR_W-1:0] w_adr_mod;

  ddr4_ca_pkg::ddr4_cmd_e  r_cmd;
  logic                    r_wr_mode;
  logic [`DDR4_ADDR_W-1:0] r_adr_mod;
  logic [1:0]              r_ba;
  logic [0:0]              r_bg;

  // ==============================
  // Command decode
  // ==============================
  always_comb begin
    if (i_ca.cs_n) begin
      w_cmd = ddr4_ca_pkg::DSEL;
    end else if (!i_ca.act_n) begin
      w_cmd = ddr4_ca_pkg::ACT;
    end else begin
      case (i_ca.adr[`DDR4_ADDR_W-1 -: 3])
        ddr4_ca_pkg::OP_MRS: w_cmd = ddr4_ca_pkg::MRS;
        ddr4_ca_pkg::OP_REF: w_cmd = ddr4_ca_pkg::REF;
        ddr4_ca_pkg::OP_PRE: w_cmd = ddr4_ca_pkg::PRE;
        ddr4_ca_pkg::OP_WR:  w_cmd = ddr4_ca_pkg::WR;
        ddr4_ca_pkg::OP_RD:  w_cmd = ddr4_ca_pkg::RD;
        ddr4_ca_pkg::OP_ZQC: w_cmd = ddr4_ca_pkg::ZQC;
        // ACT opcode with act_n high means nothing to the part
        ddr4_ca_pkg::OP_ACT,
        ddr4_ca_pkg::OP_NOP: w_cmd = ddr4_ca_pkg::NOP;
        default:             w_cmd = ddr4_ca_pkg::NOP;
      endcase
    end
  end

  assign w_wrrd    = (w_cmd == ddr4_ca_pkg::WR) || (w_cmd == ddr4_ca_pkg::RD);
  assign w_adr_mod = w_wrrd ? (i_ca.adr & `DDR4_WRRD_MASK) : i_ca.adr;

  always_ff @(posedge c0_ddr4_ck_t or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_cmd     <= ddr4_ca_pkg::DSEL;
      r_wr_mode <= 1'b0;
    end else begin
      r_cmd <= w_cmd;
      // Memory reset wins over any command
      if (!i_ca.reset_n) begin
        r_wr_mode <= 1'b0;
      end else if (w_cmd == ddr4_ca_pkg::WR) begin
        r_wr_mode <= 1'b1;
      end else if (w_cmd == ddr4_ca_pkg::RD) begin
        r_wr_mode <= 1'b0;
      end
    end
  end

  always_ff @(posedge c0_ddr4_ck_t) begin
    r_adr_mod <= w_adr_mod;
    r_ba      <= i_ca.ba;
    r_bg      <= i_ca.bg;
  end

  assign o_dev.cmd     = r_cmd;
  assign o_dev.adr_mod = r_adr_mod;
  assign o_dev.ba      = r_ba;
  assign o_dev.bg      = r_bg;
  assign o_dev.wr_mode = r_wr_mode;

endmodule

// File: hw/ddr4_cmd_tally.sv
`timescale 1ns/1ps

`include "ddr4_ca_macros.svh"

module ddr4_cmd_tally (
  input  logic                                        c0_ddr4_ck_t,
  input  logic                                        i_arst_n,
  ddr4_dev_if.dst                                     i_dev [`DDR4_NUM_DEV],
  output logic [`DDR4_NUM_RANK-1:0][`DDR4_CNT_W-1:0]  o_act_cnt,
  output logic [`DDR4_NUM_RANK-1:0][`DDR4_CNT_W-1:0]  o_wr_cnt,
  output logic [`DDR4_NUM_RANK-1:0][`DDR4_CNT_W-1:0]  o_rd_cnt,
  output logic [`DDR4_NUM_DEV-1:0][3:0]               o_dev_cmd,
  output logic [`DDR4_NUM_DEV-1:0][`DDR4_ADDR_W-1:0]  o_dev_adr,
  output logic [`DDR4_NUM_DEV-1:0][1:0]               o_dev_ba,
  output logic [`DDR4_NUM_DEV-1:0]                    o_dev_bg,
  output logic [`DDR4_NUM_DEV-1:0]                    o_wr_mode
);

  localparam logic [`DDR4_CNT_W-1:0] CNT_MAX = '1;

  ddr4_ca_pkg::ddr4_cmd_e w_rank_cmd [`DDR4_NUM_RANK];

  function automatic logic [`DDR4_CNT_W-1:0] sat_inc(
    input logic [`DDR4_CNT_W-1:0] cnt,
    input logic                   hit
  );
    return (hit && (cnt != CNT_MAX)) ? cnt + 1'b1 : cnt;
  endfunction

  // Flatten per-device outputs
  for (genvar d = 0; d < `DDR4_NUM_DEV; d++) begin : g_flat
    assign o_dev_cmd[d] = i_dev[d].cmd;
    assign o_dev_adr[d] = i_dev[d].adr_mod;
    assign o_dev_ba[d]  = i_dev[d].ba;
    assign o_dev_bg[d]  = i_dev[d].bg;
    assign o_wr_mode[d] = i_dev[d].wr_mode;
  end

  // Device r is the first part of rank r
  for (genvar r = 0; r < `DDR4_NUM_RANK; r++) begin : g_rank
    assign w_rank_cmd[r] = i_dev[r].cmd;
  end

  always_ff @(posedge c0_ddr4_ck_t or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_act_cnt <= '0;
      o_wr_cnt  <= '0;
      o_rd_cnt  <= '0;
    end else begin
      for (int r = 0; r < `DDR4_NUM_RANK; r++) begin
        o_act_cnt[r] <= sat_inc(o_act_cnt[r], w_rank_cmd[r] == ddr4_ca_pkg::ACT);
        o_wr_cnt[r]  <= sat_inc(o_wr_cnt[r], w_rank_cmd[r] == ddr4_ca_pkg::WR);
        o_rd_cnt[r]  <= sat_inc(o_rd_cnt[r], w_rank_cmd[r] == ddr4_ca_pkg::RD);
      end
    end
  end

endmodule

// File: hw/ddr4_ca_fanout_top.sv
`timescale 1ns/1ps

`include "ddr4_ca_macros.svh"

module ddr4_ca_fanout_top (
  input  logic                                        c0_ddr4_ck_t,
  input  logic                                        i_arst_n,
  input  logic                                        i_act_n,
  input  logic [`DDR4_ADDR_W-1:0]                     i_adr,
  input  logic [1:0]                                  i_ba,
  input  logic [0:0]                                  i_bg,
  input  logic [`DDR4_NUM_RANK-1:0]                   i_cs_n,
  input  logic                                        i_reset_n,
  output logic [`DDR4_NUM_RANK-1:0][`DDR4_CNT_W-1:0]  o_act_cnt,
  output logic [`DDR4_NUM_RANK-1:0][`DDR4_CNT_W-1:0]  o_wr_cnt,
  output logic [`DDR4_NUM_RANK-1:0][`DDR4_CNT_W-1:0]  o_rd_cnt,
  output logic [`DDR4_NUM_DEV-1:0][3:0]               o_dev_cmd,
  output logic [`DDR4_NUM_DEV-1:0][`DDR4_ADDR_W-1:0]  o_dev_adr,
  output logic [`DDR4_NUM_DEV-1:0][1:0]               o_dev_ba,
  output logic [`DDR4_NUM_DEV-1:0]                    o_dev_bg,
  output logic [`DDR4_NUM_DEV-1:0]                    o_wr_mode
);

  ddr4_ca_if  u_rank_if [`DDR4_NUM_RANK] ();
  ddr4_dev_if u_dev_if  [`DDR4_NUM_DEV] ();

  // ==============================
  // Input register and mirroring
  // ==============================
  ddr4_ca_mirror u_mirror (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .i_arst_n     (i_arst_n),
    .i_act_n      (i_act_n),
    .i_adr        (i_adr),
    .i_ba         (i_ba),
    .i_bg         (i_bg),
    .i_cs_n       (i_cs_n),
    .i_reset_n    (i_reset_n),
    .o_rank0      (u_rank_if[0]),
    .o_rank1      (u_rank_if[1])
  );

  // ==============================
  // Per-device decode
  // ==============================

  // Even parts on the front (rank 0), odd parts on the back (rank 1)
  for (genvar k = 0; k < `DDR4_NUM_DEV; k++) begin : g_dev
    ddr4_dev_decode u_decode (
      .c0_ddr4_ck_t (c0_ddr4_ck_t),
      .i_arst_n     (i_arst_n),
      .i_ca         (u_rank_if[k % `DDR4_NUM_RANK]),
      .o_dev        (u_dev_if[k])
    );
  end

  // ==============================
  // Command counters
  // ==============================
  ddr4_cmd_tally u_tally (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .i_arst_n     (i_arst_n),
    .i_dev        (u_dev_if),
    .o_act_cnt    (o_act_cnt),
    .o_wr_cnt     (o_wr_cnt),
    .o_rd_cnt     (o_rd_cnt),
    .o_dev_cmd    (o_dev_cmd),
    .o_dev_adr    (o_dev_adr),
    .o_dev_ba     (o_dev_ba),
    .o_dev_bg     (o_dev_bg),
    .o_wr_mode    (o_wr_mode)
  );

endmodule

// File: tb/ddr4_ca_checker.sv
`timescale 1ns/1ps

`include "ddr4_ca_macros.svh"

module ddr4_ca_checker (
  input logic                                       c0_ddr4_ck_t,
  input logic                                       i_arst_n,
  input logic [`DDR4_NUM_RANK-1:0]                  i_cs_n,
  input logic                                       i_reset_n,
  input logic [`DDR4_NUM_DEV-1:0][3:0]              o_dev_cmd,
  input logic [`DDR4_NUM_DEV-1:0]                   o_wr_mode,
  input logic [`DDR4_NUM_RANK-1:0][`DDR4_CNT_W-1:0] o_act_cnt,
  input logic [`DDR4_NUM_RANK-1:0][`DDR4_CNT_W-1:0] o_wr_cnt,
  input logic [`DDR4_NUM_RANK-1:0][`DDR4_CNT_W-1:0] o_rd_cnt
);

  int fail_count;

  initial fail_count = 0;

  // Memory reset reaches wr_mode after the input register and the decode register
  a_wr_mode_clear : assert property (@(posedge c0_ddr4_ck_t) disable iff (!i_arst_n)
    !i_reset_n |-> ##2 (o_wr_mode == '0))
  else begin
    fail_count++;
    $error("wr_mode still set two edges after memory reset");
  end

  for (genvar d = 0; d < `DDR4_NUM_DEV; d++) begin : g_dsel
    a_dsel : assert property (@(posedge c0_ddr4_ck_t) disable iff (!i_arst_n)
      i_cs_n[d % `DDR4_NUM_RANK] |-> ##2 (o_dev_cmd[d] == 4'(ddr4_ca_pkg::DSEL)))
    else begin
      fail_count++;
      $error("device %0d not DSEL two edges after its chip select was high", d);
    end
  end

  for (genvar r = 0; r < `DDR4_NUM_RANK; r++) begin : g_mono
    a_cnt_mono : assert property (@(posedge c0_ddr4_ck_t) disable iff (!i_arst_n)
      (o_act_cnt[r] >= $past(o_act_cnt[r])) && (o_wr_cnt[r] >= $past(o_wr_cnt[r])) &&
      (o_rd_cnt[r] >= $past(o_rd_cnt[r])))
    else begin
      fail_count++;
      $error("rank %0d command counter went down", r);
    end
  end

endmodule

// File: tb/ddr4_ca_tb.sv
`timescale 1ns/1ps

`include "ddr4_ca_macros.svh"

module ddr4_ca_tb;

  localparam int CLK_HALF_NS  = 20;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_CYCLES   = 400;
  localparam int DRAIN_CYCLES = 3;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 100) * 2 * CLK_HALF_NS;

  // One word as driven onto the controller pins
  typedef struct packed {
    logic                      act_n;
    logic [`DDR4_ADDR_W-1:0]   adr;
    logic [1:0]                ba;
    logic [0:0]                bg;
    logic [`DDR4_NUM_RANK-1:0] cs_n;
    logic                      reset_n;
  } bus_word_t;

  // Matches the register contents right after reset
  localparam bus_word_t IDLE_WORD = '{
    act_n: 1'b1, adr: '0, ba: '0, bg: '0, cs_n: '1, reset_n: 1'b0
  };

  logic                                       c0_ddr4_ck_t;
  logic                                       i_arst_n;
  logic                                       i_act_n;
  logic [`DDR4_ADDR_W-1:0]                    i_adr;
  logic [1:0]                                 i_ba;
  logic [0:0]                                 i_bg;
  logic [`DDR4_NUM_RANK-1:0]                  i_cs_n;
  logic                                       i_reset_n;
  logic [`DDR4_NUM_RANK-1:0][`DDR4_CNT_W-1:0] o_act_cnt;
  logic [`DDR4_NUM_RANK-1:0][`DDR4_CNT_W-1:0] o_wr_cnt;
  logic [`DDR4_NUM_RANK-1:0][`DDR4_CNT_W-1:0] o_rd_cnt;
  logic [`DDR4_NUM_DEV-1:0][3:0]              o_dev_cmd;
  logic [`DDR4_NUM_DEV-1:0][`DDR4_ADDR_W-1:0] o_dev_adr;
  logic [`DDR4_NUM_DEV-1:0][1:0]              o_dev_ba;
  logic [`DDR4_NUM_DEV-1:0]                   o_dev_bg;
  logic [`DDR4_NUM_DEV-1:0]                   o_wr_mode;

  logic [15:0] lfsr_state;
  bus_word_t   word_q [$];
  logic        exp_wr_mode [`DDR4_NUM_DEV];
  int          exp_act [`DDR4_NUM_RANK];
  int          exp_wr [`DDR4_NUM_RANK];
  int          exp_rd [`DDR4_NUM_RANK];

  ddr4_ca_fanout_top u_dut (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .i_arst_n     (i_arst_n),
    .i_act_n      (i_act_n),
    .i_adr        (i_adr),
    .i_ba         (i_ba),
    .i_bg         (i_bg),
    .i_cs_n       (i_cs_n),
    .i_reset_n    (i_reset_n),
    .o_act_cnt    (o_act_cnt),
    .o_wr_cnt     (o_wr_cnt),
    .o_rd_cnt     (o_rd_cnt),
    .o_dev_cmd    (o_dev_cmd),
    .o_dev_adr    (o_dev_adr),
    .o_dev_ba     (o_dev_ba),
    .o_dev_bg     (o_dev_bg),
    .o_wr_mode    (o_wr_mode)
  );

  bind ddr4_ca_fanout_top ddr4_ca_checker u_checker (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .i_arst_n     (i_arst_n),
    .i_cs_n       (i_cs_n),
    .i_reset_n    (i_reset_n),
    .o_dev_cmd    (o_dev_cmd),
    .o_wr_mode    (o_wr_mode),
    .o_act_cnt    (o_act_cnt),
    .o_wr_cnt     (o_wr_cnt),
    .o_rd_cnt     (o_rd_cnt)
  );

  initial begin
    c0_ddr4_ck_t = 1'b0;
    forever #(CLK_HALF_NS) c0_ddr4_ck_t = ~c0_ddr4_ck_t;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not reach its end within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

  // ==============================
  // Random source and model
  // ==============================
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Back side swaps A3/A4, A5/A6, A7/A8 and A11/A13
  function automatic logic [`DDR4_ADDR_W-1:0] mirror_adr(input logic [`DDR4_ADDR_W-1:0] a);
    logic [`DDR4_ADDR_W-1:0] m;
    m = a;
    m[3] = a[4];
    m[4] = a[3];
    m[5] = a[6];
    m[6] = a[5];
    m[7] = a[8];
    m[8] = a[7];
    m[11] = a[13];
    m[13] = a[11];
    return m;
  endfunction

  function automatic logic [3:0] model_decode(input logic cs_n, input logic act_n,
                                              input logic [2:0] op);
    if (cs_n) begin
      return ddr4_ca_pkg::DSEL;
    end
    if (!act_n) begin
      return ddr4_ca_pkg::ACT;
    end
    case (op)
      3'd0:    return ddr4_ca_pkg::MRS;
      3'd1:    return ddr4_ca_pkg::REF;
      3'd2:    return ddr4_ca_pkg::PRE;
      3'd4:    return ddr4_ca_pkg::WR;
      3'd5:    return ddr4_ca_pkg::RD;
      3'd6:    return ddr4_ca_pkg::ZQC;
      default: return ddr4_ca_pkg::NOP;
    endcase
  endfunction

  function automatic bus_word_t random_word(input int cycle);
    bus_word_t w;
    logic [1:0] sel;
    sel = 2'(take_bits(2));
    // Each rank selected on half the cycles
    case (sel)
      2'd0:    w.cs_n = 2'b10;
      2'd1:    w.cs_n = 2'b01;
      2'd2:    w.cs_n = 2'b00;
      default: w.cs_n = 2'b11;
    endcase
    w.act_n = 1'(take_bits(1));
    w.adr = `DDR4_ADDR_W'(take_bits(`DDR4_ADDR_W));
    w.ba = 2'(take_bits(2));
    w.bg = 1'(take_bits(1));
    w.reset_n = !((cycle >= 2 && cycle < 6) || (cycle >= 24 && cycle < 27));
    return w;
  endfunction

  task automatic drive_word(input bus_word_t w);
    i_act_n   = w.act_n;
    i_adr     = w.adr;
    i_ba      = w.ba;
    i_bg      = w.bg;
    i_cs_n    = w.cs_n;
    i_reset_n = w.reset_n;
  endtask

  task automatic report_mismatch(input string what);
    $display("FAILED at %0t ns: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "Mismatch against the reference model");
  endtask

  // ==============================
  // Checks
  // ==============================
  task automatic check_reset_state();
    for (int d = 0; d < `DDR4_NUM_DEV; d++) begin
      assert (o_dev_cmd[d] === 4'(ddr4_ca_pkg::DSEL) && o_wr_mode[d] === 1'b0)
      else report_mismatch($sformatf("device %0d not idle in reset", d));
    end
    for (int r = 0; r < `DDR4_NUM_RANK; r++) begin
      assert (o_act_cnt[r] === '0 && o_wr_cnt[r] === '0 && o_rd_cnt[r] === '0)
      else report_mismatch($sformatf("rank %0d counters not cleared in reset", r));
    end
  endtask

  // cur was sampled two edges ago, old three edges ago
  task automatic check_outputs(input bus_word_t cur, input bus_word_t old);
    int                      r;
    logic [3:0]              cmd;
    logic [`DDR4_ADDR_W-1:0] adr;
    logic [1:0]              ba;
    for (int d = 0; d < `DDR4_NUM_DEV; d++) begin
      r = d % `DDR4_NUM_RANK;
      cmd = model_decode(cur.cs_n[r], cur.act_n, cur.adr[`DDR4_ADDR_W-1 -: 3]);
      adr = (r == 1) ? mirror_adr(cur.adr) : cur.adr;
      ba = (r == 1) ? {cur.ba[0], cur.ba[1]} : cur.ba;
      if (cmd == ddr4_ca_pkg::WR || cmd == ddr4_ca_pkg::RD) begin
        adr = adr & ~(`DDR4_ADDR_W'(7) << 11);
      end
      if (!cur.reset_n) begin
        exp_wr_mode[d] = 1'b0;
      end else if (cmd == ddr4_ca_pkg::WR) begin
        exp_wr_mode[d] = 1'b1;
      end else if (cmd == ddr4_ca_pkg::RD) begin
        exp_wr_mode[d] = 1'b0;
      end
      assert (o_dev_cmd[d] === cmd)
      else report_mismatch($sformatf("device %0d cmd %0h, expected %0h", d, o_dev_cmd[d], cmd));
      assert (o_dev_adr[d] === adr)
      else report_mismatch($sformatf("device %0d adr %05h, expected %05h", d, o_dev_adr[d], adr));
      assert (o_dev_ba[d] === ba && o_dev_bg[d] === cur.bg)
      else report_mismatch($sformatf("device %0d bank bits differ from model", d));
      assert (o_wr_mode[d] === exp_wr_mode[d])
      else report_mismatch($sformatf("device %0d wr_mode %0b, expected %0b", d, o_wr_mode[d],
                                     exp_wr_mode[d]));
    end
    for (int k = 0; k < `DDR4_NUM_RANK; k++) begin
      cmd = model_decode(old.cs_n[k], old.act_n, old.adr[`DDR4_ADDR_W-1 -: 3]);
      exp_act[k] += (cmd == ddr4_ca_pkg::ACT);
      exp_wr[k] += (cmd == ddr4_ca_pkg::WR);
      exp_rd[k] += (cmd == ddr4_ca_pkg::RD);
      assert (o_act_cnt[k] == exp_act[k] && o_wr_cnt[k] == exp_wr[k] && o_rd_cnt[k] == exp_rd[k])
      else report_mismatch($sformatf("rank %0d counts act %0d wr %0d rd %0d, expected %0d %0d %0d",
                                     k, o_act_cnt[k], o_wr_cnt[k], o_rd_cnt[k],
                                     exp_act[k], exp_wr[k], exp_rd[k]));
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin : stimulus
    bus_word_t w;
    i_arst_n = 1'b0;
    drive_word(IDLE_WORD);
    lfsr_state = 16'd14;
    for (int d = 0; d < `DDR4_NUM_DEV; d++) begin
      exp_wr_mode[d] = 1'b0;
    end
    for (int r = 0; r < `DDR4_NUM_RANK; r++) begin
      exp_act[r] = 0;
      exp_wr[r] = 0;
      exp_rd[r] = 0;
    end
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge c0_ddr4_ck_t);
    end
    @(negedge c0_ddr4_ck_t);
    check_reset_state();
    i_arst_n = 1'b1;
    // Two reset views already in the pipeline
    word_q.push_back(IDLE_WORD);
    word_q.push_back(IDLE_WORD);
    for (int c = 0; c < NUM_CYCLES + DRAIN_CYCLES; c++) begin
      if (c > 0) begin
        @(negedge c0_ddr4_ck_t);
      end
      if (word_q.size() == 3) begin
        check_outputs(word_q[1], word_q[0]);
        void'(word_q.pop_front());
      end
      w = (c < NUM_CYCLES) ? random_word(c) : IDLE_WORD;
      drive_word(w);
      word_q.push_back(w);
    end
    if (u_dut.u_checker.fail_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "Concurrent assertions failed %0d times", u_dut.u_checker.fail_count);
    end
  end

endmodule

// File: project.f
+incdir+hw
hw/ddr4_ca_pkg.sv
hw/ddr4_ca_if.sv
hw/ddr4_dev_if.sv
hw/ddr4_ca_mirror.sv
hw/ddr4_dev_decode.sv
hw/ddr4_cmd_tally.sv
hw/ddr4_ca_fanout_top.sv
tb/ddr4_ca_checker.sv
tb/ddr4_ca_tb.sv
